// ==== hw/game_pkg.sv ====
package game_pkg;

    // screen geometry
    localparam int X_W     = 9;
    localparam int Y_W     = 8;
    localparam int COLOR_W = 12;
    localparam int ADDR_W  = 17;    // big enough for 320x240

    // 4-bit r, g, b per pixel
    localparam logic [COLOR_W-1:0] GREET_COLOR  = 12'h3a5;
    localparam logic [COLOR_W-1:0] CLEAR_COLOR  = 12'h111;
    localparam logic [COLOR_W-1:0] PLAYER_COLOR = 12'hfe0;
    localparam logic [COLOR_W-1:0] OVER_COLOR   = 12'hc21;

endpackage

// ==== hw/fb_if.sv ====
`timescale 1ns/1ns

interface fb_if;
    import game_pkg::*;

    logic [COLOR_W-1:0] data;
    logic [ADDR_W-1:0]  addr;
    logic               wren;
    logic [COLOR_W-1:0] q;      // read data, one cycle after addr

    // engine side
    modport master (
        output data, addr, wren,
        input  q
    );

    // controller or RAM side
    modport arbiter (
        input  data, addr, wren,
        output q
    );

endinterface

// ==== hw/screen_fill.sv ====
`timescale 1ns/1ns

module screen_fill #(
    parameter int SCREEN_W = 16,
    parameter int SCREEN_H = 8
) (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         enable,
    input  logic [game_pkg::COLOR_W-1:0] color,
    output logic                         finished,
    fb_if.master                         fb
);
    import game_pkg::*;

    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic           last_pixel;

    assign last_pixel = (x == X_W'(SCREEN_W - 1)) && (y == Y_W'(SCREEN_H - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            x        <= '0;
            y        <= '0;
            finished <= 1'b0;
        end else if (!finished) begin
            if (last_pixel) begin
                finished <= 1'b1;   // counters park on the last pixel
            end else if (x == X_W'(SCREEN_W - 1)) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // one write per cycle until done
    assign fb.wren = enable && !finished;
    assign fb.data = color;
    assign fb.addr = ADDR_W'(y) * ADDR_W'(SCREEN_W) + ADDR_W'(x);

endmodule

// ==== hw/player_sprite.sv ====
`timescale 1ns/1ns

module player_sprite #(
    parameter int SCREEN_W    = 16,
    parameter int SCREEN_H    = 8,
    parameter int PLAYER_SIZE = 3
) (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     enable,
    input  logic [game_pkg::X_W-1:0] player_x,
    input  logic [game_pkg::Y_W-1:0] player_y,
    output logic                     finished,
    fb_if.master                     fb
);
    import game_pkg::*;

    logic [X_W-1:0] dx;
    logic [Y_W-1:0] dy;
    logic [X_W:0]   px;     // extra bit so the right edge can't wrap
    logic [Y_W:0]   py;
    logic           on_screen;
    logic           last_cell;

    assign px        = {1'b0, player_x} + {1'b0, dx};
    assign py        = {1'b0, player_y} + {1'b0, dy};
    assign on_screen = (px < (X_W + 1)'(SCREEN_W)) && (py < (Y_W + 1)'(SCREEN_H));
    assign last_cell = (dx == X_W'(PLAYER_SIZE - 1)) && (dy == Y_W'(PLAYER_SIZE - 1));

    // walk the square row by row, one cell per cycle
    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            dx       <= '0;
            dy       <= '0;
            finished <= 1'b0;
        end else if (!finished) begin
            if (last_cell) begin
                finished <= 1'b1;
            end else if (dx == X_W'(PLAYER_SIZE - 1)) begin
                dx <= '0;
                dy <= dy + 1'b1;
            end else begin
                dx <= dx + 1'b1;
            end
        end
    end

    // off-screen cells still take their cycle, just no write
    assign fb.wren = enable && !finished && on_screen;
    assign fb.data = PLAYER_COLOR;
    assign fb.addr = ADDR_W'(py) * ADDR_W'(SCREEN_W) + ADDR_W'(px);

endmodule

// ==== hw/vga_scan.sv ====
`timescale 1ns/1ns

module vga_scan #(
    parameter int SCREEN_W = 16,
    parameter int SCREEN_H = 8
) (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         enable,
    output logic                         finished,
    output logic [game_pkg::X_W-1:0]     vga_x,
    output logic [game_pkg::Y_W-1:0]     vga_y,
    output logic [game_pkg::COLOR_W-1:0] vga_color,
    output logic                         vga_plot,
    fb_if.master                         fb
);
    import game_pkg::*;

    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic [X_W-1:0] x_q;
    logic [Y_W-1:0] y_q;
    logic           issued;     // last address already presented
    logic           reading;
    logic           last_pixel;

    assign reading    = enable && !issued;
    assign last_pixel = (x == X_W'(SCREEN_W - 1)) && (y == Y_W'(SCREEN_H - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            x        <= '0;
            y        <= '0;
            issued   <= 1'b0;
            vga_plot <= 1'b0;
            finished <= 1'b0;
        end else begin
            vga_plot <= reading;    // q arrives one cycle after addr
            if (vga_plot && issued)
                finished <= 1'b1;
            if (reading) begin
                if (last_pixel) begin
                    issued <= 1'b1;
                end else if (x == X_W'(SCREEN_W - 1)) begin
                    x <= '0;
                    y <= y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    // coordinates follow the read by one cycle
    always_ff @(posedge clock) begin
        x_q <= x;
        y_q <= y;
    end

    assign vga_x     = x_q;
    assign vga_y     = y_q;
    assign vga_color = fb.q;

    assign fb.wren = 1'b0;      // read only
    assign fb.data = '0;
    assign fb.addr = ADDR_W'(y) * ADDR_W'(SCREEN_W) + ADDR_W'(x);

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer #(
    parameter int SCREEN_W    = 16,
    parameter int SCREEN_H    = 8,
    parameter int PLAYER_SIZE = 3
) (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         enable,
    input  logic [game_pkg::X_W-1:0]     player_x,
    input  logic [game_pkg::Y_W-1:0]     player_y,
    output logic                         finished,
    output logic [game_pkg::X_W-1:0]     vga_x,
    output logic [game_pkg::Y_W-1:0]     vga_y,
    output logic [game_pkg::COLOR_W-1:0] vga_color,
    output logic                         vga_plot,
    fb_if.master                         fb
);
    import game_pkg::*;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_CLEAR  = 3'd1;
    localparam logic [2:0] S_PLAYER = 3'd2;
    localparam logic [2:0] S_VGA    = 3'd3;
    localparam logic [2:0] S_DONE   = 3'd4;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       clear_done;
    logic       player_done;
    logic       vga_done;

    fb_if clear_bus ();
    fb_if player_bus ();
    fb_if vga_bus ();

    always_ff @(posedge clock) begin
        if (!resetn || !enable)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:   next_state = S_CLEAR;
            S_CLEAR:  if (clear_done) next_state = S_PLAYER;
            S_PLAYER: if (player_done) next_state = S_VGA;
            S_VGA:    if (vga_done) next_state = S_DONE;
            S_DONE:   next_state = S_DONE;    // wait for enable to drop
            default:  next_state = S_IDLE;
        endcase
    end

    assign finished = (state == S_DONE);

    always_comb begin
        fb.data = '0;
        fb.addr = '0;
        fb.wren = 1'b0;
        case (state)
            S_CLEAR: begin
                fb.data = clear_bus.data;
                fb.addr = clear_bus.addr;
                fb.wren = clear_bus.wren;
            end
            S_PLAYER: begin
                fb.data = player_bus.data;
                fb.addr = player_bus.addr;
                fb.wren = player_bus.wren;
            end
            S_VGA: begin
                fb.data = vga_bus.data;
                fb.addr = vga_bus.addr;
                fb.wren = vga_bus.wren;
            end
            default: ;
        endcase
    end

    assign clear_bus.q  = fb.q;
    assign player_bus.q = fb.q;
    assign vga_bus.q    = fb.q;

    screen_fill #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_clear (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (state == S_CLEAR),
        .color    (CLEAR_COLOR),
        .finished (clear_done),
        .fb       (clear_bus.master)
    );

    player_sprite #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) u_player (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (state == S_PLAYER),
        .player_x (player_x),
        .player_y (player_y),
        .finished (player_done),
        .fb       (player_bus.master)
    );

    vga_scan #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_vga (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (state == S_VGA),
        .finished  (vga_done),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .vga_plot  (vga_plot),
        .fb        (vga_bus.master)
    );

endmodule

// ==== hw/game_phase_ctrl.sv ====
`timescale 1ns/1ns

module game_phase_ctrl #(
    parameter int SCREEN_W    = 16,
    parameter int SCREEN_H    = 8,
    parameter int PLAYER_SIZE = 3
) (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         enable,
    input  logic [game_pkg::X_W-1:0]     player_x,
    input  logic [game_pkg::Y_W-1:0]     player_y,
    fb_if.master                         fb,
    output logic [game_pkg::X_W-1:0]     vga_x,
    output logic [game_pkg::Y_W-1:0]     vga_y,
    output logic [game_pkg::COLOR_W-1:0] vga_color,
    output logic                         vga_plot
);
    import game_pkg::*;

    localparam logic [1:0] GREETING  = 2'd0;
    localparam logic [1:0] PLAYING   = 2'd1;
    localparam logic [1:0] GAME_OVER = 2'd2;

    logic [1:0]         phase;
    logic [1:0]         next_phase;
    logic               settle;     // one idle cycle after reset or a phase change
    logic               fill_en;
    logic               fill_done;
    logic               seq_en;
    logic               seq_done;
    logic               advance;
    logic [COLOR_W-1:0] fill_color;

    fb_if fill_bus ();
    fb_if seq_bus ();

    // greeting and game over share one fill engine, settle lets it restart
    assign fill_en    = (phase != PLAYING) && !settle;
    assign seq_en     = (phase == PLAYING);
    assign fill_color = (phase == GAME_OVER) ? OVER_COLOR : GREET_COLOR;
    assign advance    = enable && (seq_en ? seq_done : (fill_en && fill_done));

    always_comb begin
        case (phase)
            GREETING: next_phase = PLAYING;
            PLAYING:  next_phase = GAME_OVER;
            default:  next_phase = GREETING;    // game over loops back
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase  <= GREETING;
            settle <= 1'b1;
        end else begin
            settle <= advance;
            if (advance)
                phase <= next_phase;
        end
    end

    // RAM port goes to whichever child owns the phase
    assign fb.data      = seq_en ? seq_bus.data : fill_bus.data;
    assign fb.addr      = seq_en ? seq_bus.addr : fill_bus.addr;
    assign fb.wren      = seq_en ? seq_bus.wren : fill_bus.wren;
    assign fill_bus.q   = fb.q;
    assign seq_bus.q    = fb.q;

    screen_fill #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_fill (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (fill_en),
        .color    (fill_color),
        .finished (fill_done),
        .fb       (fill_bus.master)
    );

    frame_sequencer #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) u_seq (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (seq_en),
        .player_x  (player_x),
        .player_y  (player_y),
        .finished  (seq_done),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .vga_plot  (vga_plot),
        .fb        (seq_bus.master)
    );

endmodule

// ==== hw/game_top.sv ====
`timescale 1ns/1ns

module game_top #(
    parameter int SCREEN_W    = 16,
    parameter int SCREEN_H    = 8,
    parameter int PLAYER_SIZE = 3
) (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         enable,
    input  logic [game_pkg::X_W-1:0]     player_x,
    input  logic [game_pkg::Y_W-1:0]     player_y,
    input  logic [game_pkg::COLOR_W-1:0] q,
    output logic [game_pkg::COLOR_W-1:0] data,
    output logic [game_pkg::ADDR_W-1:0]  addr,
    output logic                         wren,
    output logic [game_pkg::X_W-1:0]     vga_x,
    output logic [game_pkg::Y_W-1:0]     vga_y,
    output logic [game_pkg::COLOR_W-1:0] vga_color,
    output logic                         vga_plot
);

    fb_if fb ();

    game_phase_ctrl #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) u_phase (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (enable),
        .player_x  (player_x),
        .player_y  (player_y),
        .fb        (fb.master),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .vga_plot  (vga_plot)
    );

    // frame buffer RAM pins
    assign data = fb.data;
    assign addr = fb.addr;
    assign wren = fb.wren;
    assign fb.q = q;

endmodule

// ==== bench/fb_ram_model.sv ====
`timescale 1ns/1ns

module fb_ram_model #(
    parameter int DEPTH = 128
) (
    input  logic                         clock,
    input  logic [game_pkg::COLOR_W-1:0] data,
    input  logic [game_pkg::ADDR_W-1:0]  addr,
    input  logic                         wren,
    output logic [game_pkg::COLOR_W-1:0] q
);
    import game_pkg::*;

    logic [COLOR_W-1:0] mem [DEPTH];

    // stale contents differ per address so a missed write shows up
    initial begin
        q = '0;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = COLOR_W'(i) ^ COLOR_W'(i >> COLOR_W) ^ 12'ha5a;
    end

    always @(posedge clock) begin
        if (wren && addr < DEPTH)
            mem[addr] <= data;
        q <= (addr < DEPTH) ? mem[addr] : '0;   // one cycle read latency
    end

endmodule

// ==== bench/game_sva.sv ====
`timescale 1ns/1ns

module game_sva #(
    parameter int SCREEN_W = 16,
    parameter int SCREEN_H = 8
) (
    input logic                        clock,
    input logic                        resetn,
    input logic [game_pkg::ADDR_W-1:0] addr,
    input logic                        wren,
    input logic                        vga_plot
);
    localparam int PIXELS = SCREEN_W * SCREEN_H;

    addr_in_range: assert property (
        @(posedge clock) disable iff (!resetn)
        (wren || vga_plot) |-> (addr < PIXELS)
    ) else $error("frame buffer address %0d outside the screen", addr);

    no_plot_during_write: assert property (
        @(posedge clock) disable iff (!resetn)
        !(vga_plot && wren)
    ) else $error("vga_plot and wren high together");

    // first edge out of reset is idle
    clean_reset_exit: assert property (
        @(posedge clock)
        $rose(resetn) |-> (!vga_plot && !wren)
    ) else $error("unexpected RAM or VGA activity right after reset");

endmodule

bind game_top game_sva #(
    .SCREEN_W (SCREEN_W),
    .SCREEN_H (SCREEN_H)
) u_sva (
    .clock    (clock),
    .resetn   (resetn),
    .addr     (addr),
    .wren     (wren),
    .vga_plot (vga_plot)
);

// ==== bench/tb_game.sv ====
`timescale 1ns/1ns

module tb_game;
    import game_pkg::*;

    localparam int SCREEN_W    = 16;
    localparam int SCREEN_H    = 8;
    localparam int PLAYER_SIZE = 3;
    localparam int PIXELS      = SCREEN_W * SCREEN_H;
    localparam int LOOP_CYCLES = 4 * PIXELS + PLAYER_SIZE * PLAYER_SIZE + 20;
    localparam int MAX_CYCLES  = 5 * LOOP_CYCLES + 200;  // margin covers the freeze

    logic               clock = 1'b0;
    logic               resetn = 1'b0;
    logic               enable = 1'b1;
    logic [X_W-1:0]     player_x = '0;
    logic [Y_W-1:0]     player_y = '0;
    logic [COLOR_W-1:0] q;
    logic [COLOR_W-1:0] data;
    logic [ADDR_W-1:0]  addr;
    logic               wren;
    logic [X_W-1:0]     vga_x;
    logic [Y_W-1:0]     vga_y;
    logic [COLOR_W-1:0] vga_color;
    logic               vga_plot;

    logic [31:0]        seed = 32'h5430;
    int                 cycle_count = 0;
    logic [COLOR_W-1:0] frame [PIXELS];     // screen as written so far
    int                 wr_addr_q[$];
    logic [COLOR_W-1:0] wr_data_q[$];
    int                 plot_pos_q[$];      // {vga_y, vga_x}
    logic [COLOR_W-1:0] plot_color_q[$];
    logic [COLOR_W-1:0] plot_model_q[$];

    always #5 clock = ~clock;

    game_top #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) dut0 (.*);

    fb_ram_model #(.DEPTH(PIXELS)) u_ram (.*);

    always @(posedge clock) begin
        if (resetn && wren) begin
            wr_addr_q.push_back(int'(addr));
            wr_data_q.push_back(data);
            if (addr < PIXELS)
                frame[addr] = data;
        end
        if (resetn && vga_plot) begin
            plot_pos_q.push_back({vga_y, vga_x});
            plot_color_q.push_back(vga_color);
            plot_model_q.push_back(frame[vga_y * SCREEN_W + vga_x]);
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles waiting for the DUT", cycle_count);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] wanted);
        if (actual !== wanted) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, wanted);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pop_write(output int wa, output logic [COLOR_W-1:0] wd);
        while (wr_addr_q.size() == 0)
            @(negedge clock);
        wa = wr_addr_q.pop_front();
        wd = wr_data_q.pop_front();
    endtask

    task automatic reset_behavior();
        repeat (2) begin
            @(negedge clock);
            check_value("wren", wren, 1'b0);
            check_value("vga_plot", vga_plot, 1'b0);
        end
        resetn = 1'b1;
        @(negedge clock);
        // first edge out of reset stays idle
        check_value("writes after reset", wr_addr_q.size(), 0);
        check_value("plots after reset", plot_pos_q.size(), 0);
    endtask

    // whole screen in raster order, optionally dropping enable part way
    task automatic expect_fill(input logic [COLOR_W-1:0] color, input int drop_at = -1);
        int wa;
        logic [COLOR_W-1:0] wd;
        for (int i = 0; i < PIXELS; i++) begin
            if (i == drop_at) begin
                @(negedge clock);
                enable = 1'b0;
            end
            pop_write(wa, wd);
            check_value("addr", wa, i);
            check_value("data", wd, color);
        end
    endtask

    task automatic playing_draw(input bit near_edge);
        int wa;
        logic [COLOR_W-1:0] wd;
        int px;
        int py;
        seed = lcg_next(seed);
        @(negedge clock);
        if (near_edge) begin
            player_x = X_W'(SCREEN_W - 1 - seed[25:24] % PLAYER_SIZE);
            player_y = Y_W'(SCREEN_H - 1 - seed[29:28] % PLAYER_SIZE);
        end else begin
            player_x = X_W'(seed[23:16] % SCREEN_W);
            player_y = Y_W'(seed[31:24] % SCREEN_H);
        end
        expect_fill(CLEAR_COLOR);
        for (int dy = 0; dy < PLAYER_SIZE; dy++) begin
            for (int dx = 0; dx < PLAYER_SIZE; dx++) begin
                px = player_x + dx;
                py = player_y + dy;
                if (px < SCREEN_W && py < SCREEN_H) begin   // clipped cells write nothing
                    pop_write(wa, wd);
                    check_value("addr", wa, py * SCREEN_W + px);
                    check_value("data", wd, PLAYER_COLOR);
                end
            end
        end
    endtask

    task automatic vga_readout();
        int pos;
        logic [COLOR_W-1:0] color;
        logic [COLOR_W-1:0] model;
        for (int i = 0; i < PIXELS; i++) begin
            while (plot_pos_q.size() == 0)
                @(negedge clock);
            pos   = plot_pos_q.pop_front();
            color = plot_color_q.pop_front();
            model = plot_model_q.pop_front();
            check_value("vga_y,vga_x", pos, {Y_W'(i / SCREEN_W), X_W'(i % SCREEN_W)});
            check_value("vga_color", color, model);
        end
    endtask

    task automatic game_over_loop();
        expect_fill(OVER_COLOR);
        check_value("extra vga_plot strobes", plot_pos_q.size(), 0);
        expect_fill(GREET_COLOR);
    endtask

    task automatic freeze_and_resume();
        int wa;
        logic [COLOR_W-1:0] wd;
        expect_fill(GREET_COLOR, 8);
        repeat (50) @(negedge clock);
        while (wr_addr_q.size() > 0) begin
            pop_write(wa, wd);
            check_value("data while frozen", wd, GREET_COLOR);
        end
        enable = 1'b1;
        pop_write(wa, wd);
        check_value("addr", wa, 0);
        check_value("data", wd, CLEAR_COLOR);
    endtask

    initial begin
        reset_behavior();
        expect_fill(GREET_COLOR);
        playing_draw(1'b0);
        vga_readout();
        game_over_loop();
        playing_draw(1'b1);     // second loop clips at the screen edge
        vga_readout();
        expect_fill(OVER_COLOR);
        freeze_and_resume();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/game_pkg.sv
hw/fb_if.sv
hw/screen_fill.sv
hw/player_sprite.sv
hw/vga_scan.sv
hw/frame_sequencer.sv
hw/game_phase_ctrl.sv
hw/game_top.sv
bench/fb_ram_model.sv
bench/game_sva.sv
bench/tb_game.sv

// ==== Bender.yml ====
package:
  name: game_sequencer

sources:
  - hw/game_pkg.sv
  - hw/fb_if.sv
  - hw/screen_fill.sv
  - hw/player_sprite.sv
  - hw/vga_scan.sv
  - hw/frame_sequencer.sv
  - hw/game_phase_ctrl.sv
  - hw/game_top.sv
  - target: test
    files:
      - bench/fb_ram_model.sv
      - bench/game_sva.sv
      - bench/tb_game.sv
